// File: mips_id.f
design/id_pkg.sv
design/inst_decoder.sv
design/operand_select.sv
design/id_ex_reg.sv
design/id_stage.sv
dv/tb_id_stage.sv

// File: Makefile
TOOL       = verilator
TOP        = tb_id_stage
FILELIST   = mips_id.f
FLAGS      = --binary --timing --assert
LINT_FLAGS = --lint-only --timing
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# verdict comes from the simulation output itself
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_id_stage.sv
`default_nettype none

module tb_id_stage import id_pkg::*;;

    localparam int MAX_TESTS = 48;

    logic      clk_i;
    logic      rst_n_i;
    inst_t     inst_i;
    word_t     reg1_data_i;
    word_t     reg2_data_i;
    logic      ex_wreg_i;
    reg_addr_t ex_waddr_i;
    word_t     ex_wdata_i;
    logic      mem_wreg_i;
    reg_addr_t mem_waddr_i;
    word_t     mem_wdata_i;
    logic      reg1_read_o;
    logic      reg2_read_o;
    reg_addr_t reg1_addr_o;
    reg_addr_t reg2_addr_o;
    alu_op_t   ex_aluop_o;
    alu_sel_t  ex_alusel_o;
    logic      ex_wreg_o;
    reg_addr_t ex_waddr_o;
    word_t     ex_reg1_o;
    word_t     ex_reg2_o;

    // stimulus and expected values, one row per test
    string     t_name  [MAX_TESTS];
    inst_t     t_inst  [MAX_TESTS];
    logic      t_fx_we [MAX_TESTS];
    reg_addr_t t_fx_wa [MAX_TESTS];
    word_t     t_fx_wd [MAX_TESTS];
    logic      t_fm_we [MAX_TESTS];
    reg_addr_t t_fm_wa [MAX_TESTS];
    word_t     t_fm_wd [MAX_TESTS];
    alu_op_t   t_op    [MAX_TESTS];
    alu_sel_t  t_sel   [MAX_TESTS];
    logic      t_we    [MAX_TESTS];
    reg_addr_t t_wa    [MAX_TESTS];
    logic      t_rd1   [MAX_TESTS];
    logic      t_rd2   [MAX_TESTS];
    word_t     t_imm   [MAX_TESTS];

    // forwarding for the next row added
    logic      nxt_ex_we;
    reg_addr_t nxt_ex_wa;
    word_t     nxt_ex_wd;
    logic      nxt_mem_we;
    reg_addr_t nxt_mem_wa;
    word_t     nxt_mem_wd;

    word_t  rf_model [32];
    integer seed;
    int     n_tests;
    int     pass_count;
    int     fail_count;
    int     test_errs;
    int     cycles;
    int     cycle_limit;

    id_stage dut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .reg1_data_i (reg1_data_i),
        .reg2_data_i (reg2_data_i),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .ex_wreg_i   (ex_wreg_i),
        .ex_waddr_i  (ex_waddr_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .ex_aluop_o  (ex_aluop_o),
        .ex_alusel_o (ex_alusel_o),
        .ex_wreg_o   (ex_wreg_o),
        .ex_waddr_o  (ex_waddr_o),
        .ex_reg1_o   (ex_reg1_o),
        .ex_reg2_o   (ex_reg2_o)
    );

    // register file answers in the same cycle
    assign reg1_data_i = rf_model[reg1_addr_o];
    assign reg2_data_i = rf_model[reg2_addr_o];

    always #50 clk_i = ~clk_i;

    function automatic inst_t r_inst(input int rs, input int rt, input int rd,
                                     input int sh, input logic [5:0] fn);
        return {OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic inst_t i_inst(input logic [5:0] op, input int rs, input int rt,
                                     input logic [15:0] imm16);
        return {op, rs[4:0], rt[4:0], imm16};
    endfunction

    // execute wins over memory, memory over the register file
    function automatic word_t expect_operand(input int k, input logic rd_en,
                                             input reg_addr_t addr);
        if (!rd_en)
            return t_imm[k];
        if (t_fx_we[k] && t_fx_wa[k] == addr)
            return t_fx_wd[k];
        if (t_fm_we[k] && t_fm_wa[k] == addr)
            return t_fm_wd[k];
        return rf_model[addr];
    endfunction

    task automatic set_fwd(input int ex_we, input int ex_wa, input word_t ex_wd,
                           input int mem_we, input int mem_wa, input word_t mem_wd);
        nxt_ex_we  = (ex_we != 0);
        nxt_ex_wa  = reg_addr_t'(ex_wa);
        nxt_ex_wd  = ex_wd;
        nxt_mem_we = (mem_we != 0);
        nxt_mem_wa = reg_addr_t'(mem_wa);
        nxt_mem_wd = mem_wd;
    endtask

    task automatic add_test(input string name, input inst_t inst, input alu_op_t op,
                            input alu_sel_t sel, input int we, input int wa,
                            input int r1, input int r2, input word_t imm);
        t_name[n_tests]  = name;
        t_inst[n_tests]  = inst;
        t_fx_we[n_tests] = nxt_ex_we;
        t_fx_wa[n_tests] = nxt_ex_wa;
        t_fx_wd[n_tests] = nxt_ex_wd;
        t_fm_we[n_tests] = nxt_mem_we;
        t_fm_wa[n_tests] = nxt_mem_wa;
        t_fm_wd[n_tests] = nxt_mem_wd;
        t_op[n_tests]    = op;
        t_sel[n_tests]   = sel;
        t_we[n_tests]    = (we != 0);
        t_wa[n_tests]    = reg_addr_t'(wa);
        t_rd1[n_tests]   = (r1 != 0);
        t_rd2[n_tests]   = (r2 != 0);
        t_imm[n_tests]   = imm;
        n_tests++;
        set_fwd(0, 0, 0, 0, 0, 0);  // quiet forwarding by default
    endtask

    task automatic build_table();
        set_fwd(0, 0, 0, 0, 0, 0);
        add_test("and", r_inst(1, 2, 3, 0, FN_AND), ALU_AND, SEL_LOGIC, 1, 3, 1, 1, 0);
        add_test("or", r_inst(4, 5, 6, 0, FN_OR), ALU_OR, SEL_LOGIC, 1, 6, 1, 1, 0);
        add_test("xor", r_inst(7, 8, 9, 0, FN_XOR), ALU_XOR, SEL_LOGIC, 1, 9, 1, 1, 0);
        add_test("nor", r_inst(10, 11, 12, 0, FN_NOR), ALU_NOR, SEL_LOGIC, 1, 12, 1, 1, 0);
        add_test("andi", i_inst(OP_ANDI, 13, 14, 16'h8F0F),
                 ALU_AND, SEL_LOGIC, 1, 14, 1, 0, 32'h0000_8F0F);
        add_test("ori", i_inst(OP_ORI, 15, 16, 16'hF00D),
                 ALU_OR, SEL_LOGIC, 1, 16, 1, 0, 32'h0000_F00D);
        add_test("xori", i_inst(OP_XORI, 17, 18, 16'hA5A5),
                 ALU_XOR, SEL_LOGIC, 1, 18, 1, 0, 32'h0000_A5A5);
        add_test("lui", i_inst(OP_LUI, 0, 19, 16'hBEEF),
                 ALU_LUI, SEL_LOGIC, 1, 19, 1, 0, 32'hBEEF_0000);
        // negative immediates, sign extended
        add_test("addi", i_inst(OP_ADDI, 1, 20, 16'hFFF0),
                 ALU_ADD, SEL_ARITH, 1, 20, 1, 0, 32'hFFFF_FFF0);
        add_test("addiu", i_inst(OP_ADDIU, 2, 21, 16'h8000),
                 ALU_ADDU, SEL_ARITH, 1, 21, 1, 0, 32'hFFFF_8000);
        add_test("slti", i_inst(OP_SLTI, 3, 22, 16'hFFFF),
                 ALU_SLT, SEL_ARITH, 1, 22, 1, 0, 32'hFFFF_FFFF);
        add_test("sltiu", i_inst(OP_SLTIU, 4, 23, 16'h9ABC),
                 ALU_SLTU, SEL_ARITH, 1, 23, 1, 0, 32'hFFFF_9ABC);
        add_test("add", r_inst(5, 6, 7, 0, FN_ADD), ALU_ADD, SEL_ARITH, 1, 7, 1, 1, 0);
        add_test("addu", r_inst(8, 9, 10, 0, FN_ADDU), ALU_ADDU, SEL_ARITH, 1, 10, 1, 1, 0);
        add_test("sub", r_inst(11, 12, 13, 0, FN_SUB), ALU_SUB, SEL_ARITH, 1, 13, 1, 1, 0);
        add_test("subu", r_inst(14, 15, 16, 0, FN_SUBU), ALU_SUBU, SEL_ARITH, 1, 16, 1, 1, 0);
        add_test("slt", r_inst(17, 18, 19, 0, FN_SLT), ALU_SLT, SEL_ARITH, 1, 19, 1, 1, 0);
        add_test("sltu", r_inst(20, 21, 22, 0, FN_SLTU), ALU_SLTU, SEL_ARITH, 1, 22, 1, 1, 0);
        add_test("sll", r_inst(0, 2, 4, 7, FN_SLL), ALU_SLL, SEL_SHIFT, 1, 4, 0, 1, 7);
        add_test("srl", r_inst(0, 3, 5, 31, FN_SRL), ALU_SRL, SEL_SHIFT, 1, 5, 0, 1, 31);
        add_test("sra", r_inst(0, 6, 8, 1, FN_SRA), ALU_SRA, SEL_SHIFT, 1, 8, 0, 1, 1);
        add_test("sllv", r_inst(9, 10, 11, 0, FN_SLLV), ALU_SLL, SEL_SHIFT, 1, 11, 1, 1, 0);
        add_test("srlv", r_inst(12, 13, 14, 0, FN_SRLV), ALU_SRL, SEL_SHIFT, 1, 14, 1, 1, 0);
        add_test("srav", r_inst(15, 16, 17, 0, FN_SRAV), ALU_SRA, SEL_SHIFT, 1, 17, 1, 1, 0);
        add_test("sll_rs_set", r_inst(1, 2, 4, 7, FN_SLL), ALU_NOP, SEL_NOP, 0, 0, 0, 0, 0);
        set_fwd(1, 5, 32'h1111_1111, 1, 5, 32'h2222_2222);
        add_test("fwd_ex_over_mem", r_inst(5, 6, 7, 0, FN_ADD), ALU_ADD, SEL_ARITH, 1, 7, 1, 1, 0);
        set_fwd(1, 9, 32'h4444_4444, 1, 6, 32'h3333_3333);
        add_test("fwd_mem_only", r_inst(5, 6, 7, 0, FN_ADD), ALU_ADD, SEL_ARITH, 1, 7, 1, 1, 0);
        set_fwd(0, 5, 32'h5555_5555, 0, 6, 32'h6666_6666);
        add_test("fwd_disabled", r_inst(5, 6, 7, 0, FN_ADD), ALU_ADD, SEL_ARITH, 1, 7, 1, 1, 0);
        set_fwd(1, 6, 32'h7777_7777, 1, 5, 32'h8888_8888);
        add_test("fwd_split", r_inst(5, 6, 7, 0, FN_OR), ALU_OR, SEL_LOGIC, 1, 7, 1, 1, 0);
        // moves, rt forced through forwarding
        set_fwd(1, 10, 32'h0, 0, 0, 0);
        add_test("movn_zero", r_inst(9, 10, 8, 0, FN_MOVN), ALU_MOVN, SEL_MOVE, 0, 8, 1, 1, 0);
        set_fwd(0, 0, 0, 1, 10, 32'h0000_0005);
        add_test("movn_nonzero", r_inst(9, 10, 8, 0, FN_MOVN), ALU_MOVN, SEL_MOVE, 1, 8, 1, 1, 0);
        set_fwd(1, 10, 32'h0, 0, 0, 0);
        add_test("movz_zero", r_inst(9, 10, 8, 0, FN_MOVZ), ALU_MOVZ, SEL_MOVE, 1, 8, 1, 1, 0);
        set_fwd(1, 10, 32'h8000_0000, 0, 0, 0);
        add_test("movz_nonzero", r_inst(9, 10, 8, 0, FN_MOVZ), ALU_MOVZ, SEL_MOVE, 0, 8, 1, 1, 0);
        add_test("unknown_op", i_inst(6'h3F, 1, 2, 16'h1234), ALU_NOP, SEL_NOP, 0, 0, 0, 0, 0);
    endtask

    task automatic compare(input string name, input string field,
                           input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("Fail %s %s: expected %h, actual %h", name, field, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_ex(input string name, input alu_op_t op, input alu_sel_t sel,
                            input logic we, input reg_addr_t wa,
                            input word_t r1, input word_t r2);
        compare(name, "ex_aluop", 32'(op), 32'(ex_aluop_o));
        compare(name, "ex_alusel", 32'(sel), 32'(ex_alusel_o));
        compare(name, "ex_wreg", 32'(we), 32'(ex_wreg_o));
        compare(name, "ex_waddr", 32'(wa), 32'(ex_waddr_o));
        compare(name, "ex_reg1", r1, ex_reg1_o);
        compare(name, "ex_reg2", r2, ex_reg2_o);
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("test %s ok", name);
        end else begin
            fail_count++;
            $display("test %s had %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    // run length guard
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        seed = 65;
        for (int i = 0; i < 32; i++)
            rf_model[i] = $random(seed);
        clk_i       = 1'b0;
        rst_n_i     = 1'b0;
        inst_i      = 32'hFC00_0000;  // unknown opcode, loads a bubble
        ex_wreg_i   = 1'b0;
        ex_waddr_i  = '0;
        ex_wdata_i  = '0;
        mem_wreg_i  = 1'b0;
        mem_waddr_i = '0;
        mem_wdata_i = '0;
        n_tests     = 0;
        pass_count  = 0;
        fail_count  = 0;
        test_errs   = 0;
        cycles      = 0;
        build_table();
        cycle_limit = 2 * n_tests + 10;

        repeat (3) @(negedge clk_i);
        check_ex("in_reset", ALU_NOP, SEL_NOP, 1'b0, NOP_REG_ADDR, ZERO_WORD, ZERO_WORD);
        report_test("in_reset");
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_ex("after_reset", ALU_NOP, SEL_NOP, 1'b0, NOP_REG_ADDR, ZERO_WORD, ZERO_WORD);
        report_test("after_reset");

        for (int k = 0; k < n_tests; k++) begin
            inst_i      = t_inst[k];
            ex_wreg_i   = t_fx_we[k];
            ex_waddr_i  = t_fx_wa[k];
            ex_wdata_i  = t_fx_wd[k];
            mem_wreg_i  = t_fm_we[k];
            mem_waddr_i = t_fm_wa[k];
            mem_wdata_i = t_fm_wd[k];
            @(negedge clk_i);
            compare(t_name[k], "reg1_read", 32'(t_rd1[k]), 32'(reg1_read_o));
            compare(t_name[k], "reg2_read", 32'(t_rd2[k]), 32'(reg2_read_o));
            if (t_rd1[k])
                compare(t_name[k], "reg1_addr", 32'(t_inst[k][RS_HI:RS_LO]), 32'(reg1_addr_o));
            if (t_rd2[k])
                compare(t_name[k], "reg2_addr", 32'(t_inst[k][RT_HI:RT_LO]), 32'(reg2_addr_o));
            check_ex(t_name[k], t_op[k], t_sel[k], t_we[k], t_wa[k],
                     expect_operand(k, t_rd1[k], t_inst[k][RS_HI:RS_LO]),
                     expect_operand(k, t_rd2[k], t_inst[k][RT_HI:RT_LO]));
            report_test(t_name[k]);
        end

        $display("tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/id_stage.sv
`default_nettype none

module id_stage import id_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    input  inst_t     inst_i,

    // register file read ports, data returns in the same cycle
    input  word_t     reg1_data_i,
    input  word_t     reg2_data_i,
    output logic      reg1_read_o,
    output logic      reg2_read_o,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,

    // forwarding from execute and memory
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_waddr_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_waddr_i,
    input  word_t     mem_wdata_i,

    // toward execute
    output alu_op_t   ex_aluop_o,
    output alu_sel_t  ex_alusel_o,
    output logic      ex_wreg_o,
    output reg_addr_t ex_waddr_o,
    output word_t     ex_reg1_o,
    output word_t     ex_reg2_o
);

    word_t     imm;
    alu_op_t   aluop;
    alu_sel_t  alusel;
    logic      wreg;
    reg_addr_t waddr;
    word_t     operand1;
    word_t     operand2;

    inst_decoder u_dec (
        .inst_i      (inst_i),
        .reg1_read_o (reg1_read_o),
        .reg2_read_o (reg2_read_o),
        .reg1_addr_o (reg1_addr_o),
        .reg2_addr_o (reg2_addr_o),
        .imm_o       (imm),
        .aluop_o     (aluop),
        .alusel_o    (alusel),
        .wreg_o      (wreg),
        .waddr_o     (waddr)
    );

    operand_select u_op1 (
        .read_i      (reg1_read_o),
        .addr_i      (reg1_addr_o),
        .rf_data_i   (reg1_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_waddr_i  (ex_waddr_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (operand1)
    );

    operand_select u_op2 (
        .read_i      (reg2_read_o),
        .addr_i      (reg2_addr_o),
        .rf_data_i   (reg2_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_waddr_i  (ex_waddr_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_waddr_i (mem_waddr_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (operand2)
    );

    id_ex_reg u_id_ex (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .aluop_i     (aluop),
        .alusel_i    (alusel),
        .wreg_i      (wreg),
        .waddr_i     (waddr),
        .reg1_i      (operand1),
        .reg2_i      (operand2),
        .ex_aluop_o  (ex_aluop_o),
        .ex_alusel_o (ex_alusel_o),
        .ex_wreg_o   (ex_wreg_o),
        .ex_waddr_o  (ex_waddr_o),
        .ex_reg1_o   (ex_reg1_o),
        .ex_reg2_o   (ex_reg2_o)
    );

endmodule

`default_nettype wire

// File: design/id_ex_reg.sv
`default_nettype none

module id_ex_reg import id_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,

    input  alu_op_t   aluop_i,
    input  alu_sel_t  alusel_i,
    input  logic      wreg_i,
    input  reg_addr_t waddr_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,

    output alu_op_t   ex_aluop_o,
    output alu_sel_t  ex_alusel_o,
    output logic      ex_wreg_o,
    output reg_addr_t ex_waddr_o,
    output word_t     ex_reg1_o,
    output word_t     ex_reg2_o
);

    logic wreg_final;

    // conditional moves test the forwarded rt value
    always_comb begin
        case (aluop_i)
            ALU_MOVN: wreg_final = (reg2_i != ZERO_WORD);
            ALU_MOVZ: wreg_final = (reg2_i == ZERO_WORD);
            default:  wreg_final = wreg_i;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_aluop_o  <= ALU_NOP;   // reset to a bubble
            ex_alusel_o <= SEL_NOP;
            ex_wreg_o   <= 1'b0;
            ex_waddr_o  <= NOP_REG_ADDR;
            ex_reg1_o   <= ZERO_WORD;
            ex_reg2_o   <= ZERO_WORD;
        end else begin
            ex_aluop_o  <= aluop_i;
            ex_alusel_o <= alusel_i;
            ex_wreg_o   <= wreg_final;
            ex_waddr_o  <= waddr_i;
            ex_reg1_o   <= reg1_i;
            ex_reg2_o   <= reg2_i;
        end
    end

    // a write toward execute always has a result class to write from
    ex_wreg_has_class: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ex_wreg_o |-> (ex_alusel_o != SEL_NOP)
    ) else $error("id_ex_reg: write enable with NOP result class");

endmodule

`default_nettype wire

// File: design/operand_select.sv
`default_nettype none

module operand_select import id_pkg::*; (
    input  logic      read_i,
    input  reg_addr_t addr_i,
    input  word_t     rf_data_i,
    input  word_t     imm_i,

    input  logic      ex_wreg_i,
    input  reg_addr_t ex_waddr_i,
    input  word_t     ex_wdata_i,

    input  logic      mem_wreg_i,
    input  reg_addr_t mem_waddr_i,
    input  word_t     mem_wdata_i,

    output word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    // r0 is matched like any other register
    assign ex_hit  = ex_wreg_i && (ex_waddr_i == addr_i);
    assign mem_hit = mem_wreg_i && (mem_waddr_i == addr_i);

    always_comb begin
        if (!read_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;   // youngest result wins
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = rf_data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/inst_decoder.sv
`default_nettype none

module inst_decoder import id_pkg::*; (
    input  inst_t     inst_i,

    output logic      reg1_read_o,
    output logic      reg2_read_o,
    output reg_addr_t reg1_addr_o,
    output reg_addr_t reg2_addr_o,
    output word_t     imm_o,
    output alu_op_t   aluop_o,
    output alu_sel_t  alusel_o,
    output logic      wreg_o,
    output reg_addr_t waddr_o
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT_W-1:0]  funct;
    logic [SHAMT_W-1:0]  shamt;
    logic [IMM_W-1:0]    imm16;
    reg_addr_t           rs;
    reg_addr_t           rt;
    reg_addr_t           rd;
    word_t               imm_zext;
    word_t               imm_sext;
    word_t               imm_upper;
    word_t               shamt_zext;

    assign opcode = inst_i[OP_HI:OP_LO];
    assign rs     = inst_i[RS_HI:RS_LO];
    assign rt     = inst_i[RT_HI:RT_LO];
    assign rd     = inst_i[RD_HI:RD_LO];
    assign shamt  = inst_i[SHAMT_HI:SHAMT_LO];
    assign funct  = inst_i[FUNCT_HI:FUNCT_LO];
    assign imm16  = inst_i[IMM_HI:IMM_LO];

    assign imm_zext   = {{(WORD_W-IMM_W){1'b0}}, imm16};
    assign imm_sext   = {{(WORD_W-IMM_W){imm16[IMM_W-1]}}, imm16};
    assign imm_upper  = {imm16, {(WORD_W-IMM_W){1'b0}}};  // LUI
    assign shamt_zext = {{(WORD_W-SHAMT_W){1'b0}}, shamt};

    // I-type opcode to ALU op
    function automatic alu_op_t imm_op(input logic [OPCODE_W-1:0] op);
        case (op)
            OP_ANDI:  return ALU_AND;
            OP_ORI:   return ALU_OR;
            OP_XORI:  return ALU_XOR;
            OP_LUI:   return ALU_LUI;
            OP_ADDI:  return ALU_ADD;
            OP_ADDIU: return ALU_ADDU;
            OP_SLTI:  return ALU_SLT;
            OP_SLTIU: return ALU_SLTU;
            default:  return ALU_NOP;
        endcase
    endfunction

    // SPECIAL funct to ALU op, variable shifts share the plain shift ops
    function automatic alu_op_t reg_op(input logic [FUNCT_W-1:0] fn);
        case (fn)
            FN_AND:  return ALU_AND;
            FN_OR:   return ALU_OR;
            FN_XOR:  return ALU_XOR;
            FN_NOR:  return ALU_NOR;
            FN_SLL:  return ALU_SLL;
            FN_SRL:  return ALU_SRL;
            FN_SRA:  return ALU_SRA;
            FN_SLLV: return ALU_SLL;
            FN_SRLV: return ALU_SRL;
            FN_SRAV: return ALU_SRA;
            FN_MOVN: return ALU_MOVN;
            FN_MOVZ: return ALU_MOVZ;
            FN_ADD:  return ALU_ADD;
            FN_ADDU: return ALU_ADDU;
            FN_SUB:  return ALU_SUB;
            FN_SUBU: return ALU_SUBU;
            FN_SLT:  return ALU_SLT;
            FN_SLTU: return ALU_SLTU;
            default: return ALU_NOP;
        endcase
    endfunction

    always_comb begin
        // bubble unless something below decodes
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        reg1_addr_o = rs;
        reg2_addr_o = rt;
        imm_o       = ZERO_WORD;
        aluop_o     = ALU_NOP;
        alusel_o    = SEL_NOP;
        wreg_o      = 1'b0;
        waddr_o     = NOP_REG_ADDR;

        case (opcode)
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                aluop_o     = imm_op(opcode);
                alusel_o    = SEL_LOGIC;
                imm_o       = (opcode == OP_LUI) ? imm_upper : imm_zext;
                reg1_read_o = 1'b1;  // rs against the immediate
                wreg_o      = 1'b1;
                waddr_o     = rt;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                aluop_o     = imm_op(opcode);
                alusel_o    = SEL_ARITH;
                imm_o       = imm_sext;
                reg1_read_o = 1'b1;
                wreg_o      = 1'b1;
                waddr_o     = rt;
            end
            OP_SPECIAL: begin
                case (funct)
                    FN_AND, FN_OR, FN_XOR, FN_NOR:    alusel_o = SEL_LOGIC;
                    FN_SLLV, FN_SRLV, FN_SRAV:        alusel_o = SEL_SHIFT;
                    FN_MOVN, FN_MOVZ:                 alusel_o = SEL_MOVE;
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
                    FN_SLT, FN_SLTU:                  alusel_o = SEL_ARITH;
                    default:                          alusel_o = SEL_NOP;
                endcase
                if (alusel_o != SEL_NOP) begin
                    aluop_o     = reg_op(funct);
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                    waddr_o     = rd;
                    // moves get their write enable once rt is forwarded
                    wreg_o      = (alusel_o != SEL_MOVE);
                end
            end
            default: ;
        endcase

        // immediate shifts, only with opcode and rs all zero
        if (inst_i[OP_HI:RS_LO] == '0) begin
            case (funct)
                FN_SLL, FN_SRL, FN_SRA: begin
                    aluop_o     = reg_op(funct);
                    alusel_o    = SEL_SHIFT;
                    reg1_read_o = 1'b0;  // operand 1 carries shamt
                    reg2_read_o = 1'b1;
                    imm_o       = shamt_zext;
                    wreg_o      = 1'b1;
                    waddr_o     = rd;
                end
                default: ;
            endcase
        end

        // a bubble must never reach writeback
        if (aluop_o == ALU_NOP) begin
            assert (!wreg_o)
                else $error("decoder: write enable high on NOP op");
        end
    end

endmodule

`default_nettype wire

// File: design/id_pkg.sv
`default_nettype none

package id_pkg;

    // architectural widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 8;
    localparam int ALU_SEL_W  = 3;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [WORD_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [ALU_OP_W-1:0]   alu_op_t;
    typedef logic [ALU_SEL_W-1:0]  alu_sel_t;

    // instruction fields
    localparam int OP_HI    = 31;
    localparam int OP_LO    = 26;
    localparam int RS_HI    = 25;
    localparam int RS_LO    = 21;
    localparam int RT_HI    = 20;
    localparam int RT_LO    = 16;
    localparam int RD_HI    = 15;
    localparam int RD_LO    = 11;
    localparam int SHAMT_HI = 10;
    localparam int SHAMT_LO = 6;
    localparam int FUNCT_HI = 5;
    localparam int FUNCT_LO = 0;
    localparam int IMM_HI   = 15;
    localparam int IMM_LO   = 0;

    localparam reg_addr_t NOP_REG_ADDR = '0;
    localparam word_t     ZERO_WORD    = '0;

    // primary opcodes
    localparam logic [OPCODE_W-1:0] OP_SPECIAL = 6'b000000;
    localparam logic [OPCODE_W-1:0] OP_ADDI    = 6'b001000;
    localparam logic [OPCODE_W-1:0] OP_ADDIU   = 6'b001001;
    localparam logic [OPCODE_W-1:0] OP_SLTI    = 6'b001010;
    localparam logic [OPCODE_W-1:0] OP_SLTIU   = 6'b001011;
    localparam logic [OPCODE_W-1:0] OP_ANDI    = 6'b001100;
    localparam logic [OPCODE_W-1:0] OP_ORI     = 6'b001101;
    localparam logic [OPCODE_W-1:0] OP_XORI    = 6'b001110;
    localparam logic [OPCODE_W-1:0] OP_LUI     = 6'b001111;

    // SPECIAL funct field
    localparam logic [FUNCT_W-1:0] FN_SLL  = 6'b000000;
    localparam logic [FUNCT_W-1:0] FN_SRL  = 6'b000010;
    localparam logic [FUNCT_W-1:0] FN_SRA  = 6'b000011;
    localparam logic [FUNCT_W-1:0] FN_SLLV = 6'b000100;
    localparam logic [FUNCT_W-1:0] FN_SRLV = 6'b000110;
    localparam logic [FUNCT_W-1:0] FN_SRAV = 6'b000111;
    localparam logic [FUNCT_W-1:0] FN_MOVZ = 6'b001010;
    localparam logic [FUNCT_W-1:0] FN_MOVN = 6'b001011;
    localparam logic [FUNCT_W-1:0] FN_ADD  = 6'b100000;
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;
    localparam logic [FUNCT_W-1:0] FN_SUB  = 6'b100010;
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;
    localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
    localparam logic [FUNCT_W-1:0] FN_OR   = 6'b100101;
    localparam logic [FUNCT_W-1:0] FN_XOR  = 6'b100110;
    localparam logic [FUNCT_W-1:0] FN_NOR  = 6'b100111;
    localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;
    localparam logic [FUNCT_W-1:0] FN_SLTU = 6'b101011;

    // ALU operations seen by execute
    localparam alu_op_t ALU_NOP  = 8'b0000_0000;
    localparam alu_op_t ALU_SRL  = 8'b0000_0010;
    localparam alu_op_t ALU_SRA  = 8'b0000_0011;
    localparam alu_op_t ALU_MOVZ = 8'b0000_1010;
    localparam alu_op_t ALU_MOVN = 8'b0000_1011;
    localparam alu_op_t ALU_ADD  = 8'b0010_0000;
    localparam alu_op_t ALU_ADDU = 8'b0010_0001;
    localparam alu_op_t ALU_SUB  = 8'b0010_0010;
    localparam alu_op_t ALU_SUBU = 8'b0010_0011;
    localparam alu_op_t ALU_AND  = 8'b0010_0100;
    localparam alu_op_t ALU_OR   = 8'b0010_0101;
    localparam alu_op_t ALU_XOR  = 8'b0010_0110;
    localparam alu_op_t ALU_NOR  = 8'b0010_0111;
    localparam alu_op_t ALU_SLT  = 8'b0010_1010;
    localparam alu_op_t ALU_SLTU = 8'b0010_1011;
    localparam alu_op_t ALU_LUI  = 8'b0101_1100;
    localparam alu_op_t ALU_SLL  = 8'b0111_1100;

    // result class, picks the execute result mux
    localparam alu_sel_t SEL_NOP   = 3'b000;
    localparam alu_sel_t SEL_LOGIC = 3'b001;
    localparam alu_sel_t SEL_SHIFT = 3'b010;
    localparam alu_sel_t SEL_MOVE  = 3'b011;
    localparam alu_sel_t SEL_ARITH = 3'b100;

endpackage

`default_nettype wire
